// ==== hdl/core_pkg.sv ====
package core_pkg;

    // default datapath width, overridden from the top level
    localparam int DATA_WIDTH = 8;

    // four general purpose registers
    localparam int REG_ADDR_WIDTH = 2;
    localparam int NUM_REGS = 1 << REG_ADDR_WIDTH;

    // ALU operation codes
    // 3'd7 is unused and decodes as a pass of operand A
    typedef enum logic [2:0] {
        OP_ADD      = 3'd0,
        OP_SUB      = 3'd1,
        OP_AND      = 3'd2,
        OP_OR       = 3'd3,
        OP_XOR      = 3'd4,
        OP_PASS_A   = 3'd5,
        OP_LOAD_IMM = 3'd6
    } alu_op_t;

endpackage

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file #(
    parameter int DATA_WIDTH     = core_pkg::DATA_WIDTH,
    parameter int REG_ADDR_WIDTH = core_pkg::REG_ADDR_WIDTH
) (
    input  logic                      _wr_en,
    input  logic                      reset,

    // write port, fed from the ALU result register
    input  logic                      wb_en,
    input  logic [REG_ADDR_WIDTH-1:0] wb_addr,
    input  logic [DATA_WIDTH-1:0]     wb_data,

    // left read port
    input  logic [REG_ADDR_WIDTH-1:0] rd_l_addr,
    output logic [DATA_WIDTH-1:0]     rd_l_data,

    // right read port
    input  logic [REG_ADDR_WIDTH-1:0] rd_r_addr,
    output logic [DATA_WIDTH-1:0]     rd_r_data
);

    localparam int DEPTH = 1 << REG_ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] regs [DEPTH];

    // write on the rising edge of the strobe
    always_ff @(posedge _wr_en) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // both reads are combinational and independent
    // without bypass a read in the write cycle sees the old value
    assign rd_l_data = regs[rd_l_addr];
    assign rd_r_data = regs[rd_r_addr];

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu #(
    parameter int DATA_WIDTH = core_pkg::DATA_WIDTH
) (
    input  logic                  _wr_en,
    input  logic                  reset,
    input  logic                  alu_load,
    input  core_pkg::alu_op_t     alu_op,
    input  logic [DATA_WIDTH-1:0] opnd_a,
    input  logic [DATA_WIDTH-1:0] opnd_b,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  carry,
    output logic                  zero
);

    import core_pkg::*;

    logic [DATA_WIDTH:0]   sum_ext;
    logic [DATA_WIDTH:0]   diff_ext;
    logic [DATA_WIDTH-1:0] res_next;
    logic                  carry_next;
    logic                  zero_next;

    // one extra bit holds the carry out or the borrow
    assign sum_ext  = {1'b0, opnd_a} + {1'b0, opnd_b};
    assign diff_ext = {1'b0, opnd_a} - {1'b0, opnd_b};

    always_comb begin
        carry_next = 1'b0;
        case (alu_op)
            OP_ADD: begin
                res_next   = sum_ext[DATA_WIDTH-1:0];
                carry_next = sum_ext[DATA_WIDTH];
            end
            OP_SUB: begin
                // top bit set when a < b
                res_next   = diff_ext[DATA_WIDTH-1:0];
                carry_next = diff_ext[DATA_WIDTH];
            end
            OP_AND:      res_next = opnd_a & opnd_b;
            OP_OR:       res_next = opnd_a | opnd_b;
            OP_XOR:      res_next = opnd_a ^ opnd_b;
            // immediate arrives on operand B
            OP_LOAD_IMM: res_next = opnd_b;
            default:     res_next = opnd_a;
        endcase
    end

    assign zero_next = (res_next == '0);

    // result and flags hold between instructions
    always_ff @(posedge _wr_en) begin
        if (reset) begin
            result <= '0;
            carry  <= 1'b0;
            zero   <= 1'b0;
        end else if (alu_load) begin
            result <= res_next;
            carry  <= carry_next;
            zero   <= zero_next;
        end
    end

endmodule

// ==== hdl/operand_select.sv ====
`timescale 1ns/1ps

module operand_select #(
    parameter int DATA_WIDTH = core_pkg::DATA_WIDTH
) (
    // register file reads
    input  logic [DATA_WIDTH-1:0] rd_l_data,
    input  logic [DATA_WIDTH-1:0] rd_r_data,

    // pending write-back value from the ALU result register
    input  logic [DATA_WIDTH-1:0] fwd_data,
    input  logic                  fwd_a,
    input  logic                  fwd_b,

    input  logic                  use_imm,
    input  logic [DATA_WIDTH-1:0] imm,

    output logic [DATA_WIDTH-1:0] opnd_a,
    output logic [DATA_WIDTH-1:0] opnd_b
);

    // operand A comes from the left port or the bypass
    always_comb begin
        if (fwd_a) begin
            opnd_a = fwd_data;
        end else begin
            opnd_a = rd_l_data;
        end
    end

    // immediate wins over forwarding on B
    always_comb begin
        if (use_imm) begin
            opnd_b = imm;
        end else if (fwd_b) begin
            opnd_b = fwd_data;
        end else begin
            opnd_b = rd_r_data;
        end
    end

endmodule

// ==== hdl/exec_control.sv ====
`timescale 1ns/1ps

module exec_control #(
    parameter int REG_ADDR_WIDTH = core_pkg::REG_ADDR_WIDTH
) (
    input  logic                      _wr_en,
    input  logic                      reset,

    // instruction as presented by the caller
    input  logic                      instr_valid,
    input  core_pkg::alu_op_t         op,
    input  logic [REG_ADDR_WIDTH-1:0] dst,
    input  logic [REG_ADDR_WIDTH-1:0] src_a,
    input  logic [REG_ADDR_WIDTH-1:0] src_b,

    // datapath controls
    output core_pkg::alu_op_t         alu_op,
    output logic                      use_imm,
    output logic                      alu_load,
    output logic                      fwd_a,
    output logic                      fwd_b,

    // write-back stage
    output logic                      wb_en,
    output logic [REG_ADDR_WIDTH-1:0] wb_addr,
    output logic                      result_valid
);

    import core_pkg::*;

    logic                      wb_valid;
    logic [REG_ADDR_WIDTH-1:0] wb_dst;
    logic                      reads_regs;
    logic                      hit_a;
    logic                      hit_b;

    // the spare code decodes as a pass of operand A
    always_comb begin
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_PASS_A, OP_LOAD_IMM: begin
                alu_op = op;
            end
            default: begin
                alu_op = OP_PASS_A;
            end
        endcase
    end

    assign use_imm  = (op == OP_LOAD_IMM);
    assign alu_load = instr_valid;

    // one-entry write-back stage
    always_ff @(posedge _wr_en) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= instr_valid;
        end
    end

    // destination of the pending write-back
    always_ff @(posedge _wr_en) begin
        if (instr_valid) begin
            wb_dst <= dst;
        end
    end

    assign wb_en        = wb_valid;
    assign wb_addr      = wb_dst;
    assign result_valid = wb_valid;

    // read-after-write against the pending write-back
    // a load ignores its source fields
    assign reads_regs = (op != OP_LOAD_IMM);
    assign hit_a      = wb_valid && (src_a == wb_dst);
    assign hit_b      = wb_valid && (src_b == wb_dst);

    assign fwd_a = reads_regs && hit_a;
    assign fwd_b = reads_regs && hit_b;

endmodule

// ==== hdl/reg_alu_core.sv ====
`timescale 1ns/1ps

module reg_alu_core #(
    parameter int DATA_WIDTH     = core_pkg::DATA_WIDTH,
    parameter int REG_ADDR_WIDTH = core_pkg::REG_ADDR_WIDTH
) (
    input  logic                      _wr_en,
    input  logic                      reset,

    input  logic                      instr_valid,
    input  core_pkg::alu_op_t         op,
    input  logic [REG_ADDR_WIDTH-1:0] dst,
    input  logic [REG_ADDR_WIDTH-1:0] src_a,
    input  logic [REG_ADDR_WIDTH-1:0] src_b,
    input  logic [DATA_WIDTH-1:0]     imm,

    output logic [DATA_WIDTH-1:0]     result,
    output logic                      result_valid,
    output logic                      carry,
    output logic                      zero
);

    import core_pkg::*;

    alu_op_t                   alu_op;
    logic                      use_imm;
    logic                      alu_load;
    logic                      fwd_a;
    logic                      fwd_b;
    logic                      wb_en;
    logic [REG_ADDR_WIDTH-1:0] wb_addr;
    logic [DATA_WIDTH-1:0]     rd_l_data;
    logic [DATA_WIDTH-1:0]     rd_r_data;
    logic [DATA_WIDTH-1:0]     opnd_a;
    logic [DATA_WIDTH-1:0]     opnd_b;

    exec_control #(
        .REG_ADDR_WIDTH(REG_ADDR_WIDTH)
    ) u_exec_control (
        ._wr_en      (_wr_en),
        .reset       (reset),
        .instr_valid (instr_valid),
        .op          (op),
        .dst         (dst),
        .src_a       (src_a),
        .src_b       (src_b),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .alu_load    (alu_load),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .result_valid(result_valid)
    );

    // sources address the two read ports directly
    register_file #(
        .DATA_WIDTH    (DATA_WIDTH),
        .REG_ADDR_WIDTH(REG_ADDR_WIDTH)
    ) u_register_file (
        ._wr_en   (_wr_en),
        .reset    (reset),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (result),
        .rd_l_addr(src_a),
        .rd_l_data(rd_l_data),
        .rd_r_addr(src_b),
        .rd_r_data(rd_r_data)
    );

    // registered result doubles as the forwarded value
    operand_select #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_operand_select (
        .rd_l_data(rd_l_data),
        .rd_r_data(rd_r_data),
        .fwd_data (result),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .use_imm  (use_imm),
        .imm      (imm),
        .opnd_a   (opnd_a),
        .opnd_b   (opnd_b)
    );

    alu #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_alu (
        ._wr_en  (_wr_en),
        .reset   (reset),
        .alu_load(alu_load),
        .alu_op  (alu_op),
        .opnd_a  (opnd_a),
        .opnd_b  (opnd_b),
        .result  (result),
        .carry   (carry),
        .zero    (zero)
    );

endmodule

// ==== dv/reg_alu_core_tb.sv ====
`timescale 1ns/1ps

module reg_alu_core_tb;

    import core_pkg::*;

    localparam int CLK_PERIOD = 8;
    // reset plus the cycles spent by each test in order
    localparam int TEST_CYCLES = 8 + 11 + 17 + 68 + 29 + 16;

    logic                      _wr_en;
    logic                      reset;
    logic                      instr_valid;
    alu_op_t                   op;
    logic [REG_ADDR_WIDTH-1:0] dst;
    logic [REG_ADDR_WIDTH-1:0] src_a;
    logic [REG_ADDR_WIDTH-1:0] src_b;
    logic [DATA_WIDTH-1:0]     imm;
    logic [DATA_WIDTH-1:0]     result;
    logic                      result_valid;
    logic                      carry;
    logic                      zero;

    logic [DATA_WIDTH-1:0] model_regs [NUM_REGS];
    logic [31:0]           rng_state;
    int                    errors;
    int                    checks;
    int                    tests;

    // expected outputs of the instruction issued one cycle earlier
    logic                  exp_valid;
    logic [DATA_WIDTH-1:0] exp_result;
    logic                  exp_carry;
    logic                  exp_zero;

    reg_alu_core #(
        .DATA_WIDTH    (DATA_WIDTH),
        .REG_ADDR_WIDTH(REG_ADDR_WIDTH)
    ) uut (
        ._wr_en      (_wr_en),
        .reset       (reset),
        .instr_valid (instr_valid),
        .op          (op),
        .dst         (dst),
        .src_a       (src_a),
        .src_b       (src_b),
        .imm         (imm),
        .result      (result),
        .result_valid(result_valid),
        .carry       (carry),
        .zero        (zero)
    );

    always #(CLK_PERIOD / 2) _wr_en = ~_wr_en;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic random_byte(output logic [DATA_WIDTH-1:0] v);
        rng_state = xorshift(rng_state);
        v = rng_state[DATA_WIDTH-1:0];
    endtask

    // top bit holds the carry out on add and the borrow on subtract
    function automatic logic [DATA_WIDTH:0] model_alu(input alu_op_t o,
            input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
        logic [DATA_WIDTH:0] r;
        r = '0;
        case (o)
            OP_ADD: begin
                r[DATA_WIDTH-1:0] = a + b;
                // a wrapped sum ends up below the first addend
                r[DATA_WIDTH]     = (r[DATA_WIDTH-1:0] < a);
            end
            OP_SUB:      r = {(a < b), a - b};
            OP_AND:      r[DATA_WIDTH-1:0] = a & b;
            OP_OR:       r[DATA_WIDTH-1:0] = a | b;
            OP_XOR:      r[DATA_WIDTH-1:0] = a ^ b;
            OP_LOAD_IMM: r[DATA_WIDTH-1:0] = b;
            default:     r[DATA_WIDTH-1:0] = a;
        endcase
        return r;
    endfunction

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
                               input logic [DATA_WIDTH-1:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, want, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, want, $time);
        end
    endtask

    // drive on the rising edge and check the previous instruction mid-cycle
    task automatic step(input logic valid, input alu_op_t o,
                        input logic [REG_ADDR_WIDTH-1:0] d, input logic [REG_ADDR_WIDTH-1:0] a,
                        input logic [REG_ADDR_WIDTH-1:0] b, input logic [DATA_WIDTH-1:0] value);
        logic [DATA_WIDTH-1:0] opb;
        logic [DATA_WIDTH:0]   r;
        @(posedge _wr_en);
        instr_valid <= valid;
        op          <= o;
        dst         <= d;
        src_a       <= a;
        src_b       <= b;
        imm         <= value;
        @(negedge _wr_en);
        check_flag("result_valid", result_valid, exp_valid);
        check_value("result", result, exp_result);
        check_flag("carry", carry, exp_carry);
        check_flag("zero", zero, exp_zero);
        exp_valid = valid;
        if (valid) begin
            opb = (o == OP_LOAD_IMM) ? value : model_regs[b];
            r = model_alu(o, model_regs[a], opb);
            exp_result    = r[DATA_WIDTH-1:0];
            exp_carry     = r[DATA_WIDTH];
            exp_zero      = (r[DATA_WIDTH-1:0] == '0);
            model_regs[d] = r[DATA_WIDTH-1:0];
        end
    endtask

    task automatic idle(input int n);
        repeat (n) step(1'b0, OP_PASS_A, 2'd0, 2'd0, 2'd0, 8'h00);
    endtask

    task automatic load_random_regs();
        logic [DATA_WIDTH-1:0] v;
        for (int i = 0; i < NUM_REGS; i++) begin
            random_byte(v);
            step(1'b1, OP_LOAD_IMM, 2'(i), 2'd0, 2'd0, v);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset_state();
        int e;
        e = errors;
        idle(3);
        for (int i = 0; i < NUM_REGS; i++) begin
            step(1'b1, OP_PASS_A, 2'(i), 2'(i), 2'(i), 8'h00);
            idle(1);
        end
        report_test("reset_state", e);
    endtask

    task automatic test_load_readback();
        int e;
        e = errors;
        load_random_regs();
        idle(1);
        for (int i = 0; i < NUM_REGS; i++) begin
            step(1'b1, OP_PASS_A, 2'(i), 2'(i), 2'(i), 8'h00);
            idle(2);
        end
        report_test("load_readback", e);
    endtask

    task automatic test_alu_ops();
        int e;
        logic [DATA_WIDTH-1:0] r;
        logic [DATA_WIDTH-1:0] v;
        e = errors;
        load_random_regs();
        // every fourth instruction reads one register on both ports
        for (int i = 0; i < 63; i++) begin
            random_byte(r);
            random_byte(v);
            step(1'b1, alu_op_t'(i % 7), r[5:4], r[1:0], (i % 4 == 0) ? r[1:0] : r[3:2], v);
        end
        idle(1);
        report_test("alu_ops", e);
    endtask

    task automatic test_forwarding();
        int e;
        logic [DATA_WIDTH-1:0]     r;
        logic [REG_ADDR_WIDTH-1:0] prev;
        e = errors;
        load_random_regs();
        prev = 2'd3;
        for (int i = 0; i < 24; i++) begin
            random_byte(r);
            case (i % 3)
                0:       step(1'b1, alu_op_t'(i % 6), r[1:0], prev, r[3:2], 8'h00);
                1:       step(1'b1, alu_op_t'(i % 6), r[1:0], r[3:2], prev, 8'h00);
                default: step(1'b1, alu_op_t'(i % 6), r[1:0], prev, prev, 8'h00);
            endcase
            prev = r[1:0];
        end
        idle(1);
        report_test("forwarding", e);
    endtask

    task automatic test_flag_cases();
        int e;
        e = errors;
        // 0xff + 0x01 wraps to zero with carry
        step(1'b1, OP_LOAD_IMM, 2'd0, 2'd0, 2'd0, 8'hff);
        step(1'b1, OP_LOAD_IMM, 2'd1, 2'd0, 2'd0, 8'h01);
        step(1'b1, OP_ADD, 2'd2, 2'd0, 2'd1, 8'h00);
        step(1'b1, OP_LOAD_IMM, 2'd3, 2'd0, 2'd0, 8'h5a);
        step(1'b1, OP_SUB, 2'd0, 2'd3, 2'd3, 8'h00);
        // smaller minus larger borrows
        step(1'b1, OP_LOAD_IMM, 2'd1, 2'd0, 2'd0, 8'h10);
        step(1'b1, OP_LOAD_IMM, 2'd2, 2'd0, 2'd0, 8'h20);
        step(1'b1, OP_SUB, 2'd3, 2'd1, 2'd2, 8'h00);
        idle(3);
        for (int i = 0; i < NUM_REGS; i++) begin
            step(1'b1, OP_PASS_A, 2'(i), 2'(i), 2'(i), 8'h00);
        end
        idle(1);
        report_test("flag_cases", e);
    endtask

    initial begin
        _wr_en      = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        op          = OP_ADD;
        dst         = '0;
        src_a       = '0;
        src_b       = '0;
        imm         = '0;
        rng_state   = 32'd4152;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        exp_valid   = 1'b0;
        exp_result  = '0;
        exp_carry   = 1'b0;
        exp_zero    = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge _wr_en);
        reset <= 1'b0;
        test_reset_state();
        test_load_readback();
        test_alu_ops();
        test_forwarding();
        test_flag_cases();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog at twice the expected run length
    initial begin
        #(TEST_CYCLES * CLK_PERIOD * 2);
        $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES * 2);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== reg_alu_core.f ====
hdl/core_pkg.sv
hdl/register_file.sv
hdl/alu.sv
hdl/operand_select.sv
hdl/exec_control.sv
hdl/reg_alu_core.sv
dv/reg_alu_core_tb.sv

// ==== Makefile ====
# Verilator flow for the register and ALU core
# every variable can be overridden, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
FILELIST  ?= reg_alu_core.f
TB_TOP    ?= reg_alu_core_tb
RTL_TOP   ?= reg_alu_core
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= SIMULATION PASSED

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS ?= $(filter hdl/%,$(SRCS))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TB_TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
